//--- common/cpu6_params.svh
`ifndef CPU6_PARAMS_SVH
`define CPU6_PARAMS_SVH

// datapath and address width.
`define CPU6_XLEN 32

// architectural registers, x0 included.
`define CPU6_NREGS 32

// register specifier width.
`define CPU6_REG_AW 5

`endif

//--- common/cpu6_pkg.sv
package cpu6_pkg;

   // alu function select. sltu is slt with signext cleared.
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4,
      ALU_XOR = 3'd5
   } alu_op_e;

   // what the execute stage does with an instruction.
   typedef enum logic [1:0] {
      CLS_NONE    = 2'd0,  // bubble.
      CLS_ALU     = 2'd1,  // result goes to rd.
      CLS_BRANCH  = 2'd2,  // taken/target report only.
      CLS_ILLEGAL = 2'd3   // unsupported encoding.
   } instr_class_e;

   // branch condition. bltu/bgeu reuse lt/ge with signext cleared.
   typedef enum logic [1:0] {
      BR_EQ = 2'd0,
      BR_NE = 2'd1,
      BR_LT = 2'd2,
      BR_GE = 2'd3
   } br_cond_e;

   // major opcodes handled by decode.
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_BRANCH = 7'b1100011
   } opcode_e;

endpackage

//--- common/cpu6_ex_if.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

interface cpu6_ex_if
   import cpu6_pkg::*;
   ();

   logic                    valid;
   instr_class_e            cls;
   alu_op_e                 op;
   br_cond_e                cond;
   logic                    signext;    // signed compare when set.
   logic [`CPU6_XLEN-1:0]   a;          // operand after bypass.
   logic [`CPU6_XLEN-1:0]   b;          // rs2 or immediate.
   logic [`CPU6_REG_AW-1:0] rd;
   logic [`CPU6_XLEN-1:0]   br_target;  // pc + b-immediate.

   modport decode_mp (
      output valid, cls, op, cond, signext, a, b, rd, br_target
   );

   modport execute_mp (
      input valid, cls, op, cond, signext, a, b, rd, br_target
   );

endinterface

//--- alu/cpu6_alu.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module cpu6_alu
   import cpu6_pkg::*;
   (
   input  logic [`CPU6_XLEN-1:0] a,
   input  logic [`CPU6_XLEN-1:0] b,
   input  alu_op_e               op,
   input  logic                  signext,
   output logic [`CPU6_XLEN-1:0] y,
   output logic                  zero,
   output logic                  lt
   );

   logic sel_add;
   logic sel_sub;
   logic sel_and;
   logic sel_or;
   logic sel_slt;
   logic sel_xor;

   logic [`CPU6_XLEN:0] ext_a;
   logic [`CPU6_XLEN:0] ext_b;
   logic [`CPU6_XLEN:0] neg_b;

   logic [`CPU6_XLEN:0]   add_result;
   logic [`CPU6_XLEN:0]   sub_result;
   logic [`CPU6_XLEN-1:0] and_result;
   logic [`CPU6_XLEN-1:0] or_result;
   logic [`CPU6_XLEN-1:0] slt_result;
   logic [`CPU6_XLEN-1:0] xor_result;

   // one extra bit so a signed or unsigned compare falls out of the msb.
   assign ext_a = {signext & a[`CPU6_XLEN-1], a};
   assign ext_b = {signext & b[`CPU6_XLEN-1], b};
   assign neg_b = ~ext_b + 1'b1;  // two's complement of b.

   assign sel_add = (op == ALU_ADD);
   assign sel_sub = (op == ALU_SUB);
   assign sel_and = (op == ALU_AND);
   assign sel_or  = (op == ALU_OR);
   assign sel_slt = (op == ALU_SLT);
   assign sel_xor = (op == ALU_XOR);

   assign add_result = ext_a + ext_b;
   assign sub_result = ext_a + neg_b;

   assign and_result = a & b;
   assign or_result  = a | b;
   assign xor_result = a ^ b;

   assign slt_result = {{(`CPU6_XLEN-1){1'b0}}, sub_result[`CPU6_XLEN]};

   // flags come from the difference whatever op is selected.
   assign zero = (sub_result[`CPU6_XLEN-1:0] == '0);
   assign lt   = sub_result[`CPU6_XLEN];

   // one-hot and-or mux.
   assign y = ({`CPU6_XLEN{sel_add}} & add_result[`CPU6_XLEN-1:0])
            | ({`CPU6_XLEN{sel_sub}} & sub_result[`CPU6_XLEN-1:0])
            | ({`CPU6_XLEN{sel_and}} & and_result)
            | ({`CPU6_XLEN{sel_or}}  & or_result)
            | ({`CPU6_XLEN{sel_slt}} & slt_result)
            | ({`CPU6_XLEN{sel_xor}} & xor_result);

endmodule

//--- logic/cpu6_regfile.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module cpu6_regfile (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`CPU6_REG_AW-1:0] rs1_addr,
   input  logic [`CPU6_REG_AW-1:0] rs2_addr,
   output logic [`CPU6_XLEN-1:0]   rs1_data,
   output logic [`CPU6_XLEN-1:0]   rs2_data,
   input  logic                    wr_en,
   input  logic [`CPU6_REG_AW-1:0] wr_addr,
   input  logic [`CPU6_XLEN-1:0]   wr_data
   );

   // x0 has no storage.
   logic [`CPU6_XLEN-1:0] regs [1:`CPU6_NREGS-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `CPU6_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // reads see the old value during a write, decode bypasses that case.
   always_comb begin
      if (rs1_addr == '0) begin
         rs1_data = '0;
      end else begin
         rs1_data = regs[rs1_addr];
      end
   end

   always_comb begin
      if (rs2_addr == '0) begin
         rs2_data = '0;
      end else begin
         rs2_data = regs[rs2_addr];
      end
   end

endmodule

//--- logic/cpu6_decode.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module cpu6_decode
   import cpu6_pkg::*;
   (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    instr_valid,
   input  logic [`CPU6_XLEN-1:0]   instr,
   input  logic [`CPU6_XLEN-1:0]   pc,
   output logic [`CPU6_REG_AW-1:0] rs1_addr,
   output logic [`CPU6_REG_AW-1:0] rs2_addr,
   input  logic [`CPU6_XLEN-1:0]   rs1_data,
   input  logic [`CPU6_XLEN-1:0]   rs2_data,
   input  logic                    wb_en,
   input  logic [`CPU6_REG_AW-1:0] wb_addr,
   input  logic [`CPU6_XLEN-1:0]   wb_data,
   cpu6_ex_if.decode_mp            ex
   );

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   logic [`CPU6_XLEN-1:0] imm_i;
   logic [`CPU6_XLEN-1:0] imm_b;
   logic [`CPU6_XLEN-1:0] rs1_val;
   logic [`CPU6_XLEN-1:0] rs2_val;

   instr_class_e cls;
   alu_op_e      op;
   br_cond_e     cond;
   logic         signext;
   logic         use_imm;

   assign opcode   = instr[6:0];
   assign funct3   = instr[14:12];
   assign funct7   = instr[31:25];
   assign rs1_addr = instr[19:15];
   assign rs2_addr = instr[24:20];

   assign imm_i = {{(`CPU6_XLEN-12){instr[31]}}, instr[31:20]};
   assign imm_b = {{(`CPU6_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   // take execute's result when it is writing a register read here.
   assign rs1_val = (wb_en && (wb_addr == rs1_addr)) ? wb_data : rs1_data;
   assign rs2_val = (wb_en && (wb_addr == rs2_addr)) ? wb_data : rs2_data;

   always_comb begin
      cls     = CLS_ILLEGAL;
      op      = ALU_ADD;
      cond    = BR_EQ;
      signext = 1'b1;
      use_imm = 1'b0;
      case (opcode)
         OPC_OP: begin
            cls = CLS_ALU;
            case ({funct7, funct3})
               10'b0000000_000: op = ALU_ADD;
               10'b0100000_000: op = ALU_SUB;
               10'b0000000_111: op = ALU_AND;
               10'b0000000_110: op = ALU_OR;
               10'b0000000_100: op = ALU_XOR;
               10'b0000000_010: op = ALU_SLT;
               10'b0000000_011: begin
                  op      = ALU_SLT;
                  signext = 1'b0;  // sltu.
               end
               default: cls = CLS_ILLEGAL;
            endcase
         end
         OPC_OP_IMM: begin
            cls     = CLS_ALU;
            use_imm = 1'b1;
            case (funct3)
               3'b000: op = ALU_ADD;
               3'b111: op = ALU_AND;
               3'b110: op = ALU_OR;
               3'b100: op = ALU_XOR;
               3'b010: op = ALU_SLT;
               3'b011: begin
                  op      = ALU_SLT;
                  signext = 1'b0;  // sltiu.
               end
               default: cls = CLS_ILLEGAL;  // shifts are not supported.
            endcase
         end
         OPC_BRANCH: begin
            cls = CLS_BRANCH;
            case (funct3)
               3'b000: cond = BR_EQ;
               3'b001: cond = BR_NE;
               3'b100: cond = BR_LT;
               3'b101: cond = BR_GE;
               3'b110: begin
                  cond    = BR_LT;
                  signext = 1'b0;
               end
               3'b111: begin
                  cond    = BR_GE;
                  signext = 1'b0;
               end
               default: cls = CLS_ILLEGAL;
            endcase
         end
         default: cls = CLS_ILLEGAL;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ex.valid <= 1'b0;
         ex.cls   <= CLS_NONE;
      end else begin
         ex.valid <= instr_valid;
         ex.cls   <= cls;
      end
   end

   // operand and field payload.
   always_ff @(posedge clk) begin
      ex.op        <= op;
      ex.cond      <= cond;
      ex.signext   <= signext;
      ex.a         <= rs1_val;
      ex.b         <= use_imm ? imm_i : rs2_val;
      ex.rd        <= instr[11:7];
      ex.br_target <= pc + imm_b;
   end

endmodule

//--- logic/cpu6_execute.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module cpu6_execute
   import cpu6_pkg::*;
   (
   input  logic                    clk,
   input  logic                    rst,
   cpu6_ex_if.execute_mp           ex,
   output logic                    wb_en,
   output logic [`CPU6_REG_AW-1:0] wb_addr,
   output logic [`CPU6_XLEN-1:0]   wb_data,
   output logic                    wb_valid,
   output logic [`CPU6_REG_AW-1:0] wb_rd,
   output logic [`CPU6_XLEN-1:0]   wb_result,
   output logic                    br_valid,
   output logic                    br_taken,
   output logic [`CPU6_XLEN-1:0]   br_target,
   output logic                    illegal
   );

   alu_op_e               alu_op;
   logic [`CPU6_XLEN-1:0] alu_y;
   logic                  alu_zero;
   logic                  alu_lt;
   logic                  is_alu;
   logic                  is_branch;
   logic                  taken;

   assign is_alu    = ex.valid && (ex.cls == CLS_ALU);
   assign is_branch = ex.valid && (ex.cls == CLS_BRANCH);

   // branches compare by subtraction.
   assign alu_op = (ex.cls == CLS_BRANCH) ? ALU_SUB : ex.op;

   cpu6_alu u_alu (
      .a       (ex.a),
      .b       (ex.b),
      .op      (alu_op),
      .signext (ex.signext),
      .y       (alu_y),
      .zero    (alu_zero),
      .lt      (alu_lt)
   );

   always_comb begin
      case (ex.cond)
         BR_EQ:   taken = alu_zero;
         BR_NE:   taken = !alu_zero;
         BR_LT:   taken = alu_lt;
         default: taken = !alu_lt;  // ge.
      endcase
   end

   // unregistered write port, also the bypass source for decode.
   assign wb_en   = is_alu && (ex.rd != '0);
   assign wb_addr = ex.rd;
   assign wb_data = alu_y;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid <= 1'b0;
         br_valid <= 1'b0;
         illegal  <= 1'b0;
      end else begin
         wb_valid <= is_alu;
         br_valid <= is_branch;
         illegal  <= ex.valid && (ex.cls == CLS_ILLEGAL);
      end
   end

   always_ff @(posedge clk) begin
      wb_rd     <= ex.rd;
      wb_result <= alu_y;
      br_taken  <= taken;
      br_target <= ex.br_target;
   end

endmodule

//--- logic/cpu6_exec_top.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module cpu6_exec_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    instr_valid,
   input  logic [`CPU6_XLEN-1:0]   instr,
   input  logic [`CPU6_XLEN-1:0]   pc,
   output logic                    wb_valid,
   output logic [`CPU6_REG_AW-1:0] wb_rd,
   output logic [`CPU6_XLEN-1:0]   wb_data,
   output logic                    br_valid,
   output logic                    br_taken,
   output logic [`CPU6_XLEN-1:0]   br_target,
   output logic                    illegal
   );

   logic [`CPU6_REG_AW-1:0] rs1_addr;
   logic [`CPU6_REG_AW-1:0] rs2_addr;
   logic [`CPU6_XLEN-1:0]   rs1_data;
   logic [`CPU6_XLEN-1:0]   rs2_data;

   // execute's live result, to the write port and the bypass.
   logic                    rf_wr_en;
   logic [`CPU6_REG_AW-1:0] rf_wr_addr;
   logic [`CPU6_XLEN-1:0]   rf_wr_data;

   cpu6_ex_if ex_bus ();

   cpu6_decode u_decode (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .pc          (pc),
      .rs1_addr    (rs1_addr),
      .rs2_addr    (rs2_addr),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .wb_en       (rf_wr_en),
      .wb_addr     (rf_wr_addr),
      .wb_data     (rf_wr_data),
      .ex          (ex_bus.decode_mp)
   );

   cpu6_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .rs1_addr (rs1_addr),
      .rs2_addr (rs2_addr),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr_en    (rf_wr_en),
      .wr_addr  (rf_wr_addr),
      .wr_data  (rf_wr_data)
   );

   cpu6_execute u_execute (
      .clk       (clk),
      .rst       (rst),
      .ex        (ex_bus.execute_mp),
      .wb_en     (rf_wr_en),
      .wb_addr   (rf_wr_addr),
      .wb_data   (rf_wr_data),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd),
      .wb_result (wb_data),
      .br_valid  (br_valid),
      .br_taken  (br_taken),
      .br_target (br_target),
      .illegal   (illegal)
   );

endmodule

//--- sim/tb_cpu6_exec.sv
`timescale 1ns/100ps
`include "cpu6_params.svh"

module tb_cpu6_exec;

   localparam string TEST_FILE      = "sim/cpu6_exec_tests.txt";
   localparam int    RESULT_TIMEOUT = 10;  // cycles allowed per result.
   localparam int    LATENCY        = 2;   // edges from presenting an instruction to its result.

   logic                    clk;
   logic                    rst;
   logic                    instr_valid;
   logic [`CPU6_XLEN-1:0]   instr;
   logic [`CPU6_XLEN-1:0]   pc;
   logic                    wb_valid;
   logic [`CPU6_REG_AW-1:0] wb_rd;
   logic [`CPU6_XLEN-1:0]   wb_data;
   logic                    br_valid;
   logic                    br_taken;
   logic [`CPU6_XLEN-1:0]   br_target;
   logic                    illegal;

   // one entry per test line.
   byte                     t_kind[$];
   logic [`CPU6_XLEN-1:0]   t_instr[$];
   logic [`CPU6_XLEN-1:0]   t_pc[$];
   logic [`CPU6_REG_AW-1:0] t_rd[$];
   logic                    t_taken[$];
   logic [`CPU6_XLEN-1:0]   t_value[$];  // wb_data or br_target.
   int                      issue_cycle[$];

   int num_tests;
   int pass_count;
   int fail_count;
   int cycle = 0;
   bit setup_error;
   bit test_ok;

   cpu6_exec_top DUT (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .pc          (pc),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data),
      .br_valid    (br_valid),
      .br_taken    (br_taken),
      .br_target   (br_target),
      .illegal     (illegal)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic load_tests();
      int                    fd;
      int                    got;
      int                    line_no;
      string                 line;
      byte                   kind;
      logic [`CPU6_XLEN-1:0] word;
      logic [`CPU6_XLEN-1:0] addr;
      logic [`CPU6_XLEN-1:0] exp_a;
      logic [`CPU6_XLEN-1:0] exp_b;
      line_no = 0;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the test file %s", TEST_FILE);
         setup_error = 1'b1;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         line_no++;
         if (line.getc(0) == "#" || line.getc(0) == "\n") begin
            continue;  // comment or blank line.
         end
         got = $sscanf(line, "%c %h %h %h %h", kind, word, addr, exp_a, exp_b);
         if (got != 5 || !(kind == "W" || kind == "B" || kind == "I")) begin
            $display("line %0d of %s cannot be read as a test", line_no, TEST_FILE);
            setup_error = 1'b1;
         end else begin
            t_kind.push_back(kind);
            t_instr.push_back(word);
            t_pc.push_back(addr);
            t_rd.push_back(exp_a[`CPU6_REG_AW-1:0]);
            t_taken.push_back(exp_a[0]);
            t_value.push_back(exp_b);
         end
      end
      $fclose(fd);
      num_tests = t_kind.size();
      if (num_tests == 0) begin
         $display("the test file holds no tests");
         setup_error = 1'b1;
      end
   endtask

   // one instruction per cycle, no gaps.
   task automatic issue_all();
      for (int i = 0; i < num_tests; i++) begin
         @(posedge clk);
         #1;
         instr_valid = 1'b1;
         instr       = t_instr[i];
         pc          = t_pc[i];
         issue_cycle.push_back(cycle);
      end
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      instr       = '0;
      pc          = '0;
   endtask

   task automatic log_test_result(input int idx);
      $display("test %0d %c instr %h pc %h: %s", idx, t_kind[idx], t_instr[idx], t_pc[idx],
               test_ok ? "pass" : "FAIL");
      if (test_ok) begin
         pass_count++;
      end
   endtask

   task automatic report_wrong_strobes(input int idx, input string expected);
      $display("test %0d: expected %s, got wb_valid %0b br_valid %0b illegal %0b", idx,
               expected, wb_valid, br_valid, illegal);
   endtask

   task automatic check_wb(input int idx, input logic [`CPU6_REG_AW-1:0] exp_rd,
                           input logic [`CPU6_XLEN-1:0] exp_data);
      if ({wb_valid, br_valid, illegal} !== 3'b100) begin
         report_wrong_strobes(idx, "a writeback only");
         test_ok = 1'b0;
      end
      if (wb_valid) begin
         if (wb_rd !== exp_rd) begin
            $display("MISMATCH at %0t: wb_rd expected %0d got %0d", $time, exp_rd, wb_rd);
            test_ok = 1'b0;
         end
         if (wb_data !== exp_data) begin
            $display("MISMATCH at %0t: wb_data expected %h got %h", $time, exp_data, wb_data);
            test_ok = 1'b0;
         end
      end
      log_test_result(idx);
   endtask

   task automatic check_branch(input int idx, input logic exp_taken,
                               input logic [`CPU6_XLEN-1:0] exp_target);
      if ({wb_valid, br_valid, illegal} !== 3'b010) begin
         report_wrong_strobes(idx, "a branch report only");
         test_ok = 1'b0;
      end
      if (br_valid) begin
         if (br_taken !== exp_taken) begin
            $display("MISMATCH at %0t: br_taken expected %0b got %0b", $time, exp_taken, br_taken);
            test_ok = 1'b0;
         end
         if (br_target !== exp_target) begin
            $display("MISMATCH at %0t: br_target expected %h got %h", $time, exp_target,
                     br_target);
            test_ok = 1'b0;
         end
      end
      log_test_result(idx);
   endtask

   task automatic check_illegal(input int idx);
      if ({wb_valid, br_valid, illegal} !== 3'b001) begin
         report_wrong_strobes(idx, "only the illegal strobe");
         test_ok = 1'b0;
      end
      log_test_result(idx);
   endtask

   // results come back in issue order, sampled on the falling edge.
   task automatic check_results();
      int timer;
      for (int i = 0; i < num_tests; i++) begin
         timer = 0;
         @(negedge clk);
         while (!(wb_valid || br_valid || illegal) && timer < RESULT_TIMEOUT) begin
            @(negedge clk);
            timer++;
         end
         if (!(wb_valid || br_valid || illegal)) begin
            $display("test %0d: no result within %0d cycles, checking stopped", i,
                     RESULT_TIMEOUT);
            return;
         end
         test_ok = 1'b1;
         if (cycle != issue_cycle[i] + LATENCY) begin
            $display("test %0d: result came %0d cycles after the instruction, not %0d", i,
                     cycle - issue_cycle[i], LATENCY);
            test_ok = 1'b0;
         end
         case (t_kind[i])
            "W":     check_wb(i, t_rd[i], t_value[i]);
            "B":     check_branch(i, t_taken[i], t_value[i]);
            default: check_illegal(i);
         endcase
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      pc          = '0;
      num_tests   = 0;
      pass_count  = 0;
      setup_error = 1'b0;
      load_tests();
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      if (!setup_error) begin
         fork
            issue_all();
            check_results();
         join
      end
      fail_count = num_tests - pass_count;  // unchecked tests count as failed.
      $display("tests %0d, passed %0d, failed %0d", num_tests, pass_count, fail_count);
      if (!setup_error && fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- sim/cpu6_exec_tests.txt
# kind instr pc exp_a exp_b, all values in hex
# W: exp_a is rd, exp_b is wb_data. B: exp_a is taken, exp_b is br_target. I: both unused
W 06400093 00000000 01 00000064
W FF900113 00000004 02 FFFFFFF9
W 7FF00193 00000008 03 000007FF
W 80000213 0000000C 04 FFFFF800
W 06400293 00000010 05 00000064
W 00208333 00000014 06 0000005D
W 402083B3 00000018 07 0000006B
W 0020F433 0000001C 08 00000060
W 0020E4B3 00000020 09 FFFFFFFD
W 0020C533 00000024 0A FFFFFF9D
W 001125B3 00000028 0B 00000001
W 00113633 0000002C 0C 00000000
W 0020B6B3 00000030 0D 00000001
W 0020A733 00000034 0E 00000000
W 00508793 00000038 0F 00000069
W 00F78833 0000003C 10 000000D2
W 403808B3 00000040 11 FFFFF8D3
W FFF8C913 00000044 12 0000072C
W 0F097993 00000048 13 00000020
W 5059EA13 0000004C 14 00000525
W FFFA2A93 00000050 15 00000000
W FFFA3B13 00000054 16 00000001
B 00508863 00001000 1 00001010
B FE208CE3 00001004 0 00000FFC
B 10209063 00001008 1 00001108
B 00114863 0000100C 1 0000101C
B 00115863 00001010 0 00001020
B FE116CE3 00001014 0 0000100C
B FE117CE3 00001018 1 00001010
B 0050D863 0000101C 1 0000102C
W 03708013 00002000 00 0000009B
W 00000BB3 00002004 17 00000000
I 12345C37 00002008 0 00000000
I 00309C93 0000200C 0 00000000
W 000C8D13 00002010 1A 00000000
W 40100DB3 00002014 1B FFFFFF9C

//--- all.f
+incdir+common
common/cpu6_pkg.sv
common/cpu6_ex_if.sv
alu/cpu6_alu.sv
logic/cpu6_regfile.sv
logic/cpu6_decode.sv
logic/cpu6_execute.sv
logic/cpu6_exec_top.sv
sim/tb_cpu6_exec.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_cpu6_exec

out=$(./obj_dir/Vtb_cpu6_exec)
echo "$out"

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
   exit 0
fi
exit 1
